// ==== include/div_consts.svh ====
`ifndef DIV_CONSTS_SVH
`define DIV_CONSTS_SVH

// operand width as a power of two
`define DIV_LG_W 5
`define DIV_W (1 << `DIV_LG_W)

// request tag carried through to the response
`define DIV_TAG_W 4

// result fifo entries, also the issue credit limit
`define DIV_FIFO_DEPTH 2

`endif

// ==== src/div_pkg.sv ====
`include "div_consts.svh"

package div_pkg;

   typedef enum logic
   {
      OP_DIVU = 1'b0,
      OP_REMU = 1'b1
   } div_op_t;

   // code 1 unused
   typedef enum logic [2:0]
   {
      ST_IDLE        = 3'd0,
      ST_DIVIDE      = 3'd2,
      ST_PACK_OUTPUT = 3'd3,
      ST_DONE        = 3'd4
   } div_state_t;

   typedef struct packed
   {
      div_op_t                op;
      logic [`DIV_TAG_W-1:0]  tag;
      logic [`DIV_W-1:0]      dividend;
      logic [`DIV_W-1:0]      divisor;
   } div_req_t;

   typedef struct packed
   {
      logic [`DIV_TAG_W-1:0]  tag;
      logic [`DIV_W-1:0]      result;
   } div_rsp_t;

endpackage

// ==== src/shiftregbit.sv ====
`timescale 1ns/10ps
`include "div_consts.svh"

module shiftregbit
(
   input  logic               clk,
   input  logic               reset,
   input  logic               b,
   input  logic               valid,
   output logic [`DIV_W-1:0]  out
);

   // first bit in ends up at the msb after a full run
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         out <= '0;
      end
      else if (valid)
      begin
         out <= {out[`DIV_W-2:0], b};
      end
   end

endmodule

// ==== src/unsigned_divider.sv ====
`timescale 1ns/10ps
`include "div_consts.svh"

module unsigned_divider
(
   input  logic               clk,
   input  logic               reset,
   input  logic [`DIV_W-1:0]  srcA,
   input  logic [`DIV_W-1:0]  srcB,
   input  logic               start_div,
   output logic [`DIV_W-1:0]  y,
   output logic [`DIV_W-1:0]  rem,
   output logic               ready,
   output logic               complete
);

   div_pkg::div_state_t r_state, n_state;

   logic [`DIV_W-1:0]     r_y, n_y;
   logic [`DIV_W-1:0]     r_rem, n_rem;
   logic [2*`DIV_W-1:0]   r_d, n_d;        // divisor aligned to upper half
   logic [2*`DIV_W-1:0]   r_r, n_r;        // partial remainder
   logic [2*`DIV_W-1:0]   t_shift;
   logic [`DIV_W-1:0]     t_ss;
   logic [`DIV_LG_W-1:0]  r_idx, n_idx;
   logic                  t_bit;
   logic                  t_valid;

   // ####################################################################
   // state and step counter
   // ####################################################################

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         r_state <= div_pkg::ST_IDLE;
         r_idx   <= '0;
      end
      else
      begin
         r_state <= n_state;
         r_idx   <= n_idx;
      end
   end

   always_ff @(posedge clk)
   begin
      r_y   <= n_y;
      r_rem <= n_rem;
      r_d   <= n_d;
      r_r   <= n_r;
   end

   shiftregbit ss
   (
      .clk   (clk),
      .reset (reset),
      .b     (t_bit),
      .valid (t_valid),
      .out   (t_ss)
   );

   // ####################################################################
   // restoring division, one quotient bit per cycle
   // ####################################################################

   always_comb
   begin
      n_state = r_state;
      n_y     = r_y;
      n_rem   = r_rem;
      n_d     = r_d;
      n_r     = r_r;
      n_idx   = r_idx;
      t_shift = {r_r[2*`DIV_W-2:0], 1'b0};   // top bit is zero until the last step
      t_bit   = 1'b0;
      t_valid = 1'b0;

      unique case (r_state)
         div_pkg::ST_IDLE:
         begin
            if (start_div)
            begin
               n_state = div_pkg::ST_DIVIDE;
            end
            n_d   = {srcB, {`DIV_W{1'b0}}};
            n_r   = {{`DIV_W{1'b0}}, srcA};
            n_idx = '1;                        // W-1 steps to go
         end
         div_pkg::ST_DIVIDE:
         begin
            t_valid = 1'b1;
            if (t_shift >= r_d)
            begin
               n_r   = t_shift - r_d;
               t_bit = 1'b1;
            end
            else
            begin
               n_r = t_shift;
            end
            n_idx = r_idx - `DIV_LG_W'(1);
            if (r_idx == '0)
            begin
               n_state = div_pkg::ST_PACK_OUTPUT;
            end
         end
         div_pkg::ST_PACK_OUTPUT:
         begin
            n_y     = t_ss;
            n_rem   = r_r[2*`DIV_W-1:`DIV_W];
            n_state = div_pkg::ST_DONE;
         end
         div_pkg::ST_DONE:
         begin
            n_state = div_pkg::ST_IDLE;
         end
         default:
         begin
            n_state = div_pkg::ST_IDLE;
         end
      endcase
   end

   assign ready    = (r_state == div_pkg::ST_IDLE);
   assign complete = (r_state == div_pkg::ST_DONE);
   assign y        = r_y;
   assign rem      = r_rem;

endmodule

// ==== src/div_issue_ctrl.sv ====
`timescale 1ns/10ps
`include "div_consts.svh"

module div_issue_ctrl
(
   input  logic                clk,
   input  logic                reset,
   input  div_pkg::div_req_t   req,
   input  logic                req_valid,
   output logic                req_ready,
   input  logic                core_ready,
   input  logic                complete,
   input  logic [`DIV_W-1:0]   quotient,
   input  logic [`DIV_W-1:0]   remainder,
   input  logic [1:0]          fifo_count,
   output logic                start_div,
   output logic [`DIV_W-1:0]   dividend,
   output logic [`DIV_W-1:0]   divisor,
   output logic                push,
   output div_pkg::div_rsp_t   push_data
);

   div_pkg::div_op_t        r_op;
   logic [`DIV_TAG_W-1:0]   r_tag;
   logic                    r_busy;          // op in flight, not yet pushed
   logic [2:0]              credits_used;
   logic                    accept;

   assign credits_used = {1'b0, fifo_count} + {2'b00, r_busy};
   assign req_ready    = core_ready && (credits_used < 3'(`DIV_FIFO_DEPTH));
   assign accept       = req_valid && req_ready;

   // core samples operands in the accepting cycle
   assign start_div = accept;
   assign dividend  = req.dividend;
   assign divisor   = req.divisor;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         r_busy <= 1'b0;
      end
      else if (accept)
      begin
         r_busy <= 1'b1;
      end
      else if (complete)
      begin
         r_busy <= 1'b0;
      end
   end

   always_ff @(posedge clk)
   begin
      if (accept)
      begin
         r_op  <= req.op;
         r_tag <= req.tag;
      end
   end

   // ####################################################################
   // response build on completion
   // ####################################################################

   assign push = complete;

   always_comb
   begin
      push_data.tag    = r_tag;
      push_data.result = (r_op == div_pkg::OP_REMU) ? remainder : quotient;
   end

endmodule

// ==== src/div_result_fifo.sv ====
`timescale 1ns/10ps
`include "div_consts.svh"

module div_result_fifo
(
   input  logic                clk,
   input  logic                reset,
   input  logic                push,
   input  div_pkg::div_rsp_t   push_data,
   output div_pkg::div_rsp_t   rsp,
   output logic                rsp_valid,
   input  logic                rsp_ready,
   output logic [1:0]          count
);

   div_pkg::div_rsp_t   mem [`DIV_FIFO_DEPTH];
   logic                rd_ptr;
   logic                wr_ptr;
   logic                pop;

   assign rsp_valid = (count != 2'd0);
   assign rsp       = mem[rd_ptr];
   assign pop       = rsp_valid && rsp_ready;

   always_ff @(posedge clk)
   begin
      if (push)
      begin
         mem[wr_ptr] <= push_data;            // never full here, credits guard it
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         rd_ptr <= 1'b0;
         wr_ptr <= 1'b0;
         count  <= 2'd0;
      end
      else
      begin
         if (push)
         begin
            wr_ptr <= ~wr_ptr;
         end
         if (pop)
         begin
            rd_ptr <= ~rd_ptr;
         end
         case ({push, pop})
            2'b10:   count <= count + 2'd1;
            2'b01:   count <= count - 2'd1;
            default: count <= count;          // both or neither
         endcase
      end
   end

endmodule

// ==== src/div_unit.sv ====
`timescale 1ns/10ps
`include "div_consts.svh"

module div_unit
(
   input  logic                clk,
   input  logic                reset,
   input  div_pkg::div_req_t   req,
   input  logic                req_valid,
   output logic                req_ready,
   output div_pkg::div_rsp_t   rsp,
   output logic                rsp_valid,
   input  logic                rsp_ready
);

   logic                 core_ready;
   logic                 complete;
   logic                 start_div;
   logic [`DIV_W-1:0]    dividend;
   logic [`DIV_W-1:0]    divisor;
   logic [`DIV_W-1:0]    quotient;
   logic [`DIV_W-1:0]    remainder;
   logic                 push;
   div_pkg::div_rsp_t    push_data;
   logic [1:0]           fifo_count;

   div_issue_ctrl ctrl
   (
      .clk        (clk),
      .reset      (reset),
      .req        (req),
      .req_valid  (req_valid),
      .req_ready  (req_ready),
      .core_ready (core_ready),
      .complete   (complete),
      .quotient   (quotient),
      .remainder  (remainder),
      .fifo_count (fifo_count),
      .start_div  (start_div),
      .dividend   (dividend),
      .divisor    (divisor),
      .push       (push),
      .push_data  (push_data)
   );

   unsigned_divider core
   (
      .clk       (clk),
      .reset     (reset),
      .srcA      (dividend),
      .srcB      (divisor),
      .start_div (start_div),
      .y         (quotient),
      .rem       (remainder),
      .ready     (core_ready),
      .complete  (complete)
   );

   div_result_fifo fifo
   (
      .clk       (clk),
      .reset     (reset),
      .push      (push),
      .push_data (push_data),
      .rsp       (rsp),
      .rsp_valid (rsp_valid),
      .rsp_ready (rsp_ready),
      .count     (fifo_count)
   );

endmodule

// ==== test/div_unit_properties.sv ====
`timescale 1ns/10ps
`include "div_consts.svh"

module div_unit_properties
(
   input logic                  clk,
   input logic                  reset,
   input logic                  start_div,
   input div_pkg::div_state_t   core_state,
   input logic                  push,
   input logic [1:0]            fifo_count,
   input div_pkg::div_rsp_t     rsp,
   input logic                  rsp_valid,
   input logic                  rsp_ready
);

   // room in the fifo for every completed op
   no_push_when_full: assert property (@(posedge clk) disable iff (reset)
      push |-> (fifo_count < 2'(`DIV_FIFO_DEPTH)))
      else $error("result pushed while the fifo was full");

   rsp_hold: assert property (@(posedge clk) disable iff (reset)
      (rsp_valid && !rsp_ready) |=> (rsp_valid && $stable(rsp)))
      else $error("response changed or dropped under back-pressure");

   start_launches_divide: assert property (@(posedge clk) disable iff (reset)
      start_div |=> (core_state == div_pkg::ST_DIVIDE))
      else $error("core did not start dividing after start_div");

   count_in_range: assert property (@(posedge clk) disable iff (reset)
      fifo_count <= 2'(`DIV_FIFO_DEPTH))
      else $error("fifo count above its depth");

endmodule

bind div_unit div_unit_properties props
(
   .clk        (clk),
   .reset      (reset),
   .start_div  (start_div),
   .core_state (core.r_state),
   .push       (push),
   .fifo_count (fifo_count),
   .rsp        (rsp),
   .rsp_valid  (rsp_valid),
   .rsp_ready  (rsp_ready)
);

// ==== test/div_unit_tb.sv ====
`timescale 1ns/10ps
`include "div_consts.svh"

module div_unit_tb;

   localparam int NUM_RANDOM  = 200;
   localparam int NUM_REQ     = NUM_RANDOM + 10;
   localparam int CYCLE_LIMIT = NUM_REQ * (`DIV_W + 10) * 4;

   logic                clk;
   logic                reset;
   div_pkg::div_req_t   req;
   logic                req_valid;
   logic                req_ready;
   div_pkg::div_rsp_t   rsp;
   logic                rsp_valid;
   logic                rsp_ready;

   logic [31:0]         lfsr = 32'hab92;
   div_pkg::div_rsp_t   expected_q[$];
   div_pkg::div_rsp_t   last_rsp;
   string               test_name = "reset";
   int                  cycle = 0;
   int                  accept_cycle = 0;
   int                  rsp_cycle = 0;
   int                  rsp_count = 0;
   logic                random_ready = 1'b0;

   div_unit UUT
   (
      .clk       (clk),
      .reset     (reset),
      .req       (req),
      .req_valid (req_valid),
      .req_ready (req_ready),
      .rsp       (rsp),
      .rsp_valid (rsp_valid),
      .rsp_ready (rsp_ready)
   );

   initial
   begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   always @(posedge clk)
   begin
      cycle++;
      if (cycle > CYCLE_LIMIT)
      begin
         fail_run("Timeout: the run did not finish within the cycle limit");
      end
   end

   // ####################################################################
   // random numbers and reference model
   // ####################################################################

   function automatic logic lfsr_step();
      logic fb;
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];   // x^32+x^22+x^2+x+1
      lfsr = {lfsr[30:0], fb};
      return fb;
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         v = {v[30:0], lfsr_step()};
      end
      return v;
   endfunction

   function automatic div_pkg::div_rsp_t model_rsp(input div_pkg::div_req_t r);
      div_pkg::div_rsp_t   m;
      logic [`DIV_W-1:0]   q;
      logic [`DIV_W-1:0]   rm;
      if (r.divisor == '0)
      begin
         q  = '1;                                // divide by zero rule
         rm = r.dividend;
      end
      else
      begin
         q  = r.dividend / r.divisor;
         rm = r.dividend % r.divisor;
      end
      m.tag    = r.tag;
      m.result = (r.op == div_pkg::OP_REMU) ? rm : q;
      return m;
   endfunction

   function automatic div_pkg::div_req_t make_req(input div_pkg::div_op_t op,
                                                  input logic [`DIV_W-1:0] a,
                                                  input logic [`DIV_W-1:0] b);
      div_pkg::div_req_t r;
      r.op       = op;
      r.tag      = `DIV_TAG_W'(rand_bits(`DIV_TAG_W));
      r.dividend = a;
      r.divisor  = b;
      return r;
   endfunction

   function automatic div_pkg::div_req_t random_req();
      div_pkg::div_op_t    op;
      logic [`DIV_W-1:0]   a;
      logic [`DIV_W-1:0]   b;
      op = (rand_bits(1) == 32'd1) ? div_pkg::OP_REMU : div_pkg::OP_DIVU;
      a  = `DIV_W'(rand_bits(`DIV_W));
      b  = `DIV_W'(rand_bits(`DIV_W)) >> rand_bits(`DIV_LG_W);   // spread divisor sizes
      return make_req(op, a, b);
   endfunction

   // ####################################################################
   // compare tasks
   // ####################################################################

   task automatic fail_run(input string msg);
      $display("%s", msg);
      $display("Test failed");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic check_rsp(input string name, input div_pkg::div_rsp_t exp,
                            input div_pkg::div_rsp_t act);
      if (act !== exp)
      begin
         fail_run($sformatf("Fail %s: expected tag %0h result %0h, actual tag %0h result %0h",
                            name, exp.tag, exp.result, act.tag, act.result));
      end
   endtask

   task automatic check_result(input string name, input div_pkg::div_op_t op,
                               input logic [`DIV_W-1:0] exp, input logic [`DIV_W-1:0] act);
      if (act !== exp)
      begin
         fail_run($sformatf("Fail %s (%s): expected %0h, actual %0h",
                            name, op.name(), exp, act));
      end
   endtask

   task automatic check_flag(input string name, input logic exp, input logic act);
      if (act !== exp)
      begin
         fail_run($sformatf("Fail %s: expected %0b, actual %0b", name, exp, act));
      end
   endtask

   task automatic check_count(input string name, input int exp, input int act);
      if (act != exp)
      begin
         fail_run($sformatf("Fail %s: expected %0d cycles, actual %0d", name, exp, act));
      end
   endtask

   // handshakes seen here complete on the next rising edge
   always @(negedge clk)
   begin
      if (!reset)
      begin
         if (req_valid && req_ready)
         begin
            expected_q.push_back(model_rsp(req));
            accept_cycle = cycle;
         end
         if (rsp_valid && rsp_ready)
         begin
            if (expected_q.size() == 0)
            begin
               fail_run("a response came out with no request outstanding");
            end
            else
            begin
               check_rsp(test_name, expected_q.pop_front(), rsp);
               last_rsp  = rsp;
               rsp_cycle = cycle;
               rsp_count++;
            end
         end
      end
   end

   // ####################################################################
   // stimulus
   // ####################################################################

   task automatic next_cycle();
      @(posedge clk);
      #1;
      if (random_ready)
      begin
         rsp_ready = lfsr_step();
      end
   endtask

   task automatic idle(input int n);
      repeat (n) next_cycle();
   endtask

   task automatic send_req(input div_pkg::div_req_t r);
      logic taken;
      req       = r;
      req_valid = 1'b1;
      taken     = 1'b0;
      while (!taken)
      begin
         @(negedge clk);
         taken = req_ready;
         next_cycle();
      end
      req_valid = 1'b0;
   endtask

   task automatic wait_rsp(input int target);
      while (rsp_count < target)
      begin
         next_cycle();
      end
   endtask

   task automatic run_one(input string name, input div_pkg::div_op_t op,
                          input logic [`DIV_W-1:0] a, input logic [`DIV_W-1:0] b,
                          input logic [`DIV_W-1:0] exp);
      int target;
      test_name = name;
      target    = rsp_count + 1;
      send_req(make_req(op, a, b));
      wait_rsp(target);
      check_result(name, op, exp, last_rsp.result);
   endtask

   initial
   begin
      int target;
      reset     = 1'b1;
      req       = '0;
      req_valid = 1'b0;
      rsp_ready = 1'b1;
      repeat (5) @(posedge clk);
      #1;
      reset = 1'b0;

      @(negedge clk);
      check_flag("reset req_ready", 1'b1, req_ready);
      check_flag("reset rsp_valid", 1'b0, rsp_valid);
      next_cycle();

      run_one("divide", div_pkg::OP_DIVU, `DIV_W'(100), `DIV_W'(7), `DIV_W'(14));
      check_count("latency", `DIV_W + 3, rsp_cycle - accept_cycle);   // accept to take edge
      run_one("remainder", div_pkg::OP_REMU, `DIV_W'(100), `DIV_W'(7), `DIV_W'(2));
      run_one("small dividend", div_pkg::OP_DIVU, `DIV_W'(5), `DIV_W'(9), `DIV_W'(0));
      run_one("small dividend", div_pkg::OP_REMU, `DIV_W'(5), `DIV_W'(9), `DIV_W'(5));
      run_one("divisor one", div_pkg::OP_DIVU, `DIV_W'(32'hdeadbeef), `DIV_W'(1),
              `DIV_W'(32'hdeadbeef));
      run_one("divisor one", div_pkg::OP_REMU, `DIV_W'(32'hdeadbeef), `DIV_W'(1), `DIV_W'(0));
      run_one("divisor zero", div_pkg::OP_DIVU, `DIV_W'(1234), `DIV_W'(0), '1);
      run_one("divisor zero", div_pkg::OP_REMU, `DIV_W'(1234), `DIV_W'(0), `DIV_W'(1234));

      test_name    = "random";
      target       = rsp_count + NUM_RANDOM;
      random_ready = 1'b1;
      for (int i = 0; i < NUM_RANDOM; i++)
      begin
         send_req(random_req());
         idle(rand_bits(2));
      end
      random_ready = 1'b0;
      rsp_ready    = 1'b1;
      wait_rsp(target);

      // two results parked, credits used up
      test_name = "backpressure";
      rsp_ready = 1'b0;
      target    = rsp_count + 2;
      send_req(random_req());
      send_req(random_req());
      idle(`DIV_W + 4);
      @(negedge clk);
      check_flag("credits used req_ready", 1'b0, req_ready);
      check_flag("backpressure rsp_valid", 1'b1, rsp_valid);
      next_cycle();
      rsp_ready = 1'b1;
      wait_rsp(target);

      if (expected_q.size() != 0)
      begin
         fail_run("responses still outstanding at the end of the run");
      end
      else
      begin
         $display("Test passed");
         $finish;
      end
   end

endmodule

// ==== div_unit.f ====
+incdir+include
src/div_pkg.sv
src/shiftregbit.sv
src/unsigned_divider.sv
src/div_issue_ctrl.sv
src/div_result_fifo.sv
src/div_unit.sv
test/div_unit_properties.sv
test/div_unit_tb.sv

// ==== Makefile ====
# Verilator build for the divide unit testbench

VERILATOR ?= verilator
TOP       ?= div_unit_tb
FLIST     ?= div_unit.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
